// ==== Bender.yml ====
package:
  name: ooo_core

sources:
  # Design, in compile order
  - hw/ooo_pkg.sv
  - hw/dispatch_unit.sv
  - hw/exec_lane.sv
  - hw/completion_buffer.sv
  - hw/ooo_core_top.sv

  # Testbench, top module ooo_core_tb
  - target: simulation
    files:
      - test/tb_clock_gen.sv
      - test/completion_buffer_checker.sv
      - test/ooo_core_tb.sv

// ==== hw/completion_buffer.sv ====
// ----------------------------------------
// Completion buffer, in-order commit
// and exception flush from the head
// ----------------------------------------
`timescale 1ns/10ps

module completion_buffer #(
  parameter int NUM_ENTRY = 8,
  parameter int NUM_LANES = 3,
  localparam int IDX_W = $clog2(NUM_ENTRY)
) (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  alloc,
  input  ooo_pkg::lane_result_t results [NUM_LANES],
  output logic [IDX_W-1:0]      cur_tail,
  output logic                  full,
  output logic                  empty,
  output logic                  flush,
  output logic                  commit_valid,
  output ooo_pkg::commit_t      commit,
  output logic                  exc_valid,
  output ooo_pkg::exc_cause_t   exc_cause,
  output ooo_pkg::epc_t         exc_epc
);

  // Entry contents apart from the valid flag
  typedef struct packed {
    logic                 exception;
    logic [4:0]           rd;
    logic                 wen;
    ooo_pkg::cb_payload_u payload;
  } cb_entry_t;

  // Pointers carry one wrap bit above the index
  logic [IDX_W:0]   head;
  logic [IDX_W:0]   tail;
  logic [IDX_W-1:0] head_sel;

  // Set when a lane has written the slot
  logic [NUM_ENTRY-1:0] valid;
  cb_entry_t            entries [NUM_ENTRY];

  // Head entry as seen this cycle
  cb_entry_t            head_ent;
  logic                 head_valid;

  // Slot written by each lane
  logic [IDX_W-1:0]     wr_sel [NUM_LANES];

  assign head_sel   = head[IDX_W-1:0];
  assign cur_tail   = tail[IDX_W-1:0];
  assign head_ent   = entries[head_sel];
  assign head_valid = valid[head_sel];

  // Same index, wrap bits apart means every slot is taken
  assign full  = (head[IDX_W-1:0] == tail[IDX_W-1:0]) && (head[IDX_W] != tail[IDX_W]);
  assign empty = (head == tail);

  // A finished head either retires or traps
  assign commit_valid = head_valid & ~head_ent.exception;
  assign exc_valid    = head_valid & head_ent.exception;
  assign flush        = exc_valid;

  // Head decode through the payload union
  always_comb begin
    commit.rd  = head_ent.rd;
    commit.wen = head_ent.wen;
    if (exc_valid) begin
      // Exception view
      commit.data = '0;
      exc_cause   = head_ent.payload.exc.cause;
      exc_epc     = head_ent.payload.exc.epc;
    end else begin
      // Data view
      commit.data = head_ent.payload.data;
      exc_cause   = ooo_pkg::EXC_NONE;
      exc_epc     = '0;
    end
  end

  // Low bits of each lane's slot tag
  always_comb begin
    for (int l = 0; l < NUM_LANES; l++) begin
      wr_sel[l] = results[l].idx[IDX_W-1:0];
    end
  end

  // Head moves on commit, tail on allocation, both return to zero on flush
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      head <= '0;
      tail <= '0;
    end else if (flush) begin
      head <= '0;
      tail <= '0;
    end else begin
      if (commit_valid) begin
        head <= head + 1'b1;
      end
      if (alloc) begin
        tail <= tail + 1'b1;
      end
    end
  end

  // Valid flags
  // Lanes always target distinct unfinished slots, never the retiring head
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      valid <= '0;
    end else if (flush) begin
      valid <= '0;
    end else begin
      if (commit_valid) begin
        valid[head_sel] <= 1'b0;
      end
      for (int l = 0; l < NUM_LANES; l++) begin
        if (results[l].ready) begin
          valid[wr_sel[l]] <= 1'b1;
        end
      end
    end
  end

  // Entry storage, written at the edge closing the lane's ready cycle
  always_ff @(posedge CLK) begin
    for (int l = 0; l < NUM_LANES; l++) begin
      if (results[l].ready) begin
        entries[wr_sel[l]].exception <= results[l].exception;
        entries[wr_sel[l]].rd        <= results[l].rd;
        // x0 is never written back
        entries[wr_sel[l]].wen       <= (results[l].rd != 5'd0);
        entries[wr_sel[l]].payload   <= results[l].payload;
      end
    end
  end

endmodule

// ==== hw/dispatch_unit.sv ====
// ----------------------------------------
// Dispatch: issue stall, slot allocation
// and lowest-free-lane steering
// ----------------------------------------
`timescale 1ns/10ps

module dispatch_unit #(
  parameter int NUM_ENTRY = 8,
  parameter int NUM_LANES = 3,
  localparam int IDX_W = $clog2(NUM_ENTRY)
) (
  input  logic                   CLK,
  input  logic                   nRST,
  input  logic                   issue_valid,
  input  ooo_pkg::issue_req_t    issue_req,
  input  logic [IDX_W-1:0]       cur_tail,
  input  logic                   full,
  input  logic                   flush,
  input  logic [NUM_LANES-1:0]   busy,
  output logic                   issue_stall,
  output logic                   alloc,
  output logic [NUM_LANES-1:0]   start,
  output ooo_pkg::lane_req_t     lane_req
);

  logic [NUM_LANES-1:0] free;
  logic [NUM_LANES-1:0] first_free;
  logic                 accept;
  logic                 is_nop;

  // Lanes not currently holding an instruction
  assign free = ~busy;

  // Isolate the lowest set bit, giving a one-hot pick of the lowest free lane
  assign first_free = free & (~free + 1'b1);

  // Hold issue while the buffer is full, all lanes are taken, or a flush retires
  assign issue_stall = full | ~(|free) | flush;

  assign accept = issue_valid & ~issue_stall;
  assign is_nop = (issue_req.op == ooo_pkg::OP_NOP);

  // NOPs are consumed here and never take a slot or a lane
  assign alloc = accept & ~is_nop;

  // Start pulse to the chosen lane only
  assign start = alloc ? first_free : '0;

  // Request register shared by all lanes
  // The started lane samples it one cycle after its start edge
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      lane_req <= '0;
    end else if (flush) begin
      lane_req <= '0;
    end else if (alloc) begin
      lane_req.op  <= issue_req.op;
      lane_req.rd  <= issue_req.rd;
      lane_req.opa <= issue_req.opa;
      lane_req.opb <= issue_req.opb;
      // Slot taken at the current tail
      lane_req.idx <= ooo_pkg::slot_t'(cur_tail);
      // Only the low PC bits fit the exception payload
      lane_req.epc <= issue_req.pc[27:0];
    end
  end

endmodule

// ==== hw/exec_lane.sv ====
// ----------------------------------------
// Variable-latency integer lane
// ALU ops, multiply and divide
// ----------------------------------------
`timescale 1ns/10ps

module exec_lane (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  start,
  input  logic                  flush,
  input  ooo_pkg::lane_req_t    req,
  output logic                  busy,
  output ooo_pkg::lane_result_t result
);

  // Set for the cycle in which the dispatch request register is valid for us
  logic                 grab;
  // Remaining cycles before ready
  logic [2:0]           count;
  logic                 ready;

  // Captured result fields
  ooo_pkg::slot_t       idx_q;
  logic [4:0]           rd_q;
  logic                 exc_q;
  ooo_pkg::cb_payload_u payload_q;

  // Combinational result of the presented request
  ooo_pkg::word_t       data_c;
  ooo_pkg::exc_cause_t  cause_c;
  ooo_pkg::cb_payload_u payload_c;
  logic [2:0]           lat_c;

  always_comb begin
    data_c  = '0;
    cause_c = ooo_pkg::EXC_NONE;
    // Countdown starts one below the latency since capture costs one cycle
    lat_c   = 3'(ooo_pkg::ALU_LATENCY - 1);
    case (req.op)
      ooo_pkg::OP_ADD: data_c = req.opa + req.opb;
      ooo_pkg::OP_SUB: data_c = req.opa - req.opb;
      ooo_pkg::OP_XOR: data_c = req.opa ^ req.opb;
      // Shift amount from the low five bits only
      ooo_pkg::OP_SLL: data_c = req.opa << req.opb[4:0];
      ooo_pkg::OP_MUL: begin
        // Low half of the product
        data_c = req.opa * req.opb;
        lat_c  = 3'(ooo_pkg::MUL_LATENCY - 1);
      end
      ooo_pkg::OP_DIV: begin
        lat_c = 3'(ooo_pkg::DIV_LATENCY - 1);
        // Unsigned quotient, zero divisor traps
        if (req.opb == '0) begin
          cause_c = ooo_pkg::EXC_DIV_ZERO;
        end else begin
          data_c = req.opa / req.opb;
        end
      end
      // ILLEGAL and anything unexpected trap
      default: cause_c = ooo_pkg::EXC_ILLEGAL;
    endcase
  end

  // Fill one view of the payload union
  always_comb begin
    if (cause_c != ooo_pkg::EXC_NONE) begin
      payload_c.exc.cause = cause_c;
      payload_c.exc.epc   = req.epc;
    end else begin
      payload_c.data = data_c;
    end
  end

  // Lane control: start, capture, countdown, release
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      busy  <= 1'b0;
      grab  <= 1'b0;
      count <= '0;
    end else if (flush) begin
      // Work in flight is dropped
      busy  <= 1'b0;
      grab  <= 1'b0;
      count <= '0;
    end else if (start) begin
      busy <= 1'b1;
      grab <= 1'b1;
    end else if (grab) begin
      grab  <= 1'b0;
      count <= lat_c;
    end else if (busy) begin
      // Free again at the edge that ends the ready cycle
      if (count == '0) begin
        busy <= 1'b0;
      end else begin
        count <= count - 1'b1;
      end
    end
  end

  // Result payload, held until the buffer takes it
  always_ff @(posedge CLK) begin
    if (grab) begin
      idx_q     <= req.idx;
      rd_q      <= req.rd;
      exc_q     <= (cause_c != ooo_pkg::EXC_NONE);
      payload_q <= payload_c;
    end
  end

  // Ready for exactly one cycle, once the countdown is spent
  assign ready = busy & ~grab & (count == '0);

  assign result = '{
    ready:     ready,
    idx:       idx_q,
    rd:        rd_q,
    exception: exc_q,
    payload:   payload_q
  };

endmodule

// ==== hw/ooo_core_top.sv ====
// ----------------------------------------
// Retirement path top level
// ----------------------------------------
`timescale 1ns/10ps

module ooo_core_top #(
  parameter int NUM_ENTRY = 8,
  parameter int NUM_LANES = 3
) (
  input  logic                CLK,
  input  logic                nRST,
  input  logic                issue_valid,
  input  ooo_pkg::issue_req_t issue_req,
  output logic                issue_stall,
  output logic                commit_valid,
  output ooo_pkg::commit_t    commit,
  output logic                exc_valid,
  output ooo_pkg::exc_cause_t exc_cause,
  output ooo_pkg::epc_t       exc_epc,
  output logic                cb_full,
  output logic                cb_empty
);

  // Dispatch and buffer handshake
  logic                           alloc;
  logic                           flush;
  logic [$clog2(NUM_ENTRY)-1:0]   cur_tail;

  // Lane control and results
  logic [NUM_LANES-1:0]           busy;
  logic [NUM_LANES-1:0]           start;
  ooo_pkg::lane_req_t             lane_req;
  ooo_pkg::lane_result_t          lane_res [NUM_LANES];

  dispatch_unit #(
    .NUM_ENTRY (NUM_ENTRY),
    .NUM_LANES (NUM_LANES)
  ) u_dispatch (
    .CLK         (CLK),
    .nRST        (nRST),
    .issue_valid (issue_valid),
    .issue_req   (issue_req),
    .cur_tail    (cur_tail),
    .full        (cb_full),
    .flush       (flush),
    .busy        (busy),
    .issue_stall (issue_stall),
    .alloc       (alloc),
    .start       (start),
    .lane_req    (lane_req)
  );

  // Identical lanes sharing one request bus
  for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
    exec_lane u_lane (
      .CLK    (CLK),
      .nRST   (nRST),
      .start  (start[g]),
      .flush  (flush),
      .req    (lane_req),
      .busy   (busy[g]),
      .result (lane_res[g])
    );
  end

  completion_buffer #(
    .NUM_ENTRY (NUM_ENTRY),
    .NUM_LANES (NUM_LANES)
  ) u_cb (
    .CLK          (CLK),
    .nRST         (nRST),
    .alloc        (alloc),
    .results      (lane_res),
    .cur_tail     (cur_tail),
    .full         (cb_full),
    .empty        (cb_empty),
    .flush        (flush),
    .commit_valid (commit_valid),
    .commit       (commit),
    .exc_valid    (exc_valid),
    .exc_cause    (exc_cause),
    .exc_epc      (exc_epc)
  );

endmodule

// ==== hw/ooo_pkg.sv ====
// ----------------------------------------
// Shared types for the retirement path
// Op codes, causes, request and result structs
// ----------------------------------------

package ooo_pkg;

  // Data word of the integer datapath
  typedef logic [31:0] word_t;

  // Slot index as carried between blocks
  // Wide enough for buffers of up to 64 entries, receivers use the low bits
  localparam int SLOT_W = 6;
  typedef logic [SLOT_W-1:0] slot_t;

  // Exception PC keeps the low 28 bits of the instruction PC
  typedef logic [27:0] epc_t;

  // Op encoding, NOP is zero and never allocates
  typedef enum logic [2:0] {
    OP_NOP     = 3'd0,
    OP_ADD     = 3'd1,
    OP_SUB     = 3'd2,
    OP_XOR     = 3'd3,
    OP_SLL     = 3'd4,
    OP_MUL     = 3'd5,
    OP_DIV     = 3'd6,
    OP_ILLEGAL = 3'd7
  } op_t;

  // Exception causes reported at the head
  typedef enum logic [3:0] {
    EXC_NONE     = 4'd0,
    EXC_DIV_ZERO = 4'd1,
    EXC_ILLEGAL  = 4'd2
  } exc_cause_t;

  // Cycles from issue acceptance to ready result
  localparam int unsigned ALU_LATENCY = 1;
  localparam int unsigned MUL_LATENCY = 3;
  localparam int unsigned DIV_LATENCY = 6;

  // Decoded instruction with operand values, as seen at issue
  typedef struct packed {
    op_t        op;
    logic [4:0] rd;
    word_t      opa;
    word_t      opb;
    word_t      pc;
  } issue_req_t;

  // Request handed to a lane, tagged with its buffer slot
  typedef struct packed {
    op_t        op;
    logic [4:0] rd;
    word_t      opa;
    word_t      opb;
    slot_t      idx;
    epc_t       epc;
  } lane_req_t;

  // Exception view of an entry payload
  typedef struct packed {
    exc_cause_t cause;
    epc_t       epc;
  } exc_view_t;

  // One payload word, either result data or cause plus PC
  typedef union packed {
    word_t     data;
    exc_view_t exc;
  } cb_payload_u;

  // Lane write port into the completion buffer
  typedef struct packed {
    logic        ready;
    slot_t       idx;
    logic [4:0]  rd;
    logic        exception;
    cb_payload_u payload;
  } lane_result_t;

  // Register file write request at retirement
  typedef struct packed {
    logic [4:0] rd;
    word_t      data;
    logic       wen;
  } commit_t;

endpackage

// ==== sim.f ====
hw/ooo_pkg.sv
hw/dispatch_unit.sv
hw/exec_lane.sv
hw/completion_buffer.sv
hw/ooo_core_top.sv
test/tb_clock_gen.sv
test/completion_buffer_checker.sv
test/ooo_core_tb.sv

// ==== test/completion_buffer_checker.sv ====
// ----------------------------------------
// Concurrent assertions bound into
// the completion buffer
// ----------------------------------------
`timescale 1ns/10ps

module completion_buffer_checker (
  input logic CLK,
  input logic nRST,
  input logic alloc,
  input logic full,
  input logic empty,
  input logic commit_valid,
  input logic exc_valid
);

  // Failed assertions, picked up by the testbench summary
  int unsigned fail_count = 0;

  // Head either retires or traps, never both
  a_commit_or_exc: assert property (
    @(posedge CLK) disable iff (!nRST) !(commit_valid && exc_valid)
  ) else begin
    $error("commit_valid and exc_valid high in the same cycle");
    fail_count++;
  end

  // Nothing can retire from an empty buffer
  a_no_commit_empty: assert property (
    @(posedge CLK) disable iff (!nRST) !(commit_valid && empty)
  ) else begin
    $error("commit_valid high while the buffer is empty");
    fail_count++;
  end

  // Dispatch must stall on full
  a_no_alloc_full: assert property (
    @(posedge CLK) disable iff (!nRST) !(alloc && full)
  ) else begin
    $error("slot allocated while the buffer is full");
    fail_count++;
  end

  // Flush clears the pointers in one edge
  a_empty_after_exc: assert property (
    @(posedge CLK) disable iff (!nRST) exc_valid |=> empty
  ) else begin
    $error("buffer not empty in the cycle after an exception");
    fail_count++;
  end

endmodule

// ==== test/ooo_core_tb.sv ====
// ----------------------------------------
// Retirement path testbench: stimulus,
// reference model and in-order compare
// ----------------------------------------
`timescale 1ns/10ps

module ooo_core_tb;

  // Three lanes keep at most about six slots busy behind one divide
  // so a four-entry buffer is needed to reach full
  localparam int NUM_ENTRY = 4;
  localparam int NUM_LANES = 3;
  // Requests issued over all tests including NOPs
  localparam int N_INSTR    = 39;
  localparam int MAX_CYCLES = 40 * N_INSTR + 200;
  localparam logic [31:0] SEED = 32'h0c54_238e;

  // Expected outcome of one allocated request
  typedef struct packed {
    logic                exc;
    ooo_pkg::exc_cause_t cause;
    ooo_pkg::epc_t       epc;
    logic [4:0]          rd;
    ooo_pkg::word_t      data;
    logic                wen;
  } expect_t;

  logic                CLK;
  logic                nRST;
  logic                issue_valid;
  ooo_pkg::issue_req_t issue_req;
  logic                issue_stall;
  logic                commit_valid;
  ooo_pkg::commit_t    commit;
  logic                exc_valid;
  ooo_pkg::exc_cause_t exc_cause;
  ooo_pkg::epc_t       exc_epc;
  logic                cb_full;
  logic                cb_empty;

  // Outstanding requests in program order
  expect_t        exp_q [$];
  int unsigned    errors     = 0;
  int unsigned    commits    = 0;
  int unsigned    exceptions = 0;
  int unsigned    cycles;
  logic           seen_full;
  ooo_pkg::word_t pc_now;

  tb_clock_gen #(.PERIOD(8), .RESET_CYCLES(5)) u_clk (
    .CLK  (CLK),
    .nRST (nRST)
  );

  ooo_core_top #(
    .NUM_ENTRY (NUM_ENTRY),
    .NUM_LANES (NUM_LANES)
  ) u_dut (
    .CLK          (CLK),
    .nRST         (nRST),
    .issue_valid  (issue_valid),
    .issue_req    (issue_req),
    .issue_stall  (issue_stall),
    .commit_valid (commit_valid),
    .commit       (commit),
    .exc_valid    (exc_valid),
    .exc_cause    (exc_cause),
    .exc_epc      (exc_epc),
    .cb_full      (cb_full),
    .cb_empty     (cb_empty)
  );

  bind completion_buffer completion_buffer_checker u_cb_chk (
    .CLK          (CLK),
    .nRST         (nRST),
    .alloc        (alloc),
    .full         (full),
    .empty        (empty),
    .commit_valid (commit_valid),
    .exc_valid    (exc_valid)
  );

  // Expected retirement from the op rules
  function automatic expect_t model(input ooo_pkg::issue_req_t req);
    expect_t e;
    e     = '0;
    e.rd  = req.rd;
    e.wen = (req.rd != 5'd0);
    e.epc = req.pc[27:0];
    case (req.op)
      ooo_pkg::OP_ADD: e.data = req.opa + req.opb;
      ooo_pkg::OP_SUB: e.data = req.opa - req.opb;
      ooo_pkg::OP_XOR: e.data = req.opa ^ req.opb;
      ooo_pkg::OP_SLL: e.data = req.opa << req.opb[4:0];
      ooo_pkg::OP_MUL: e.data = req.opa * req.opb;
      ooo_pkg::OP_DIV: begin
        if (req.opb == 32'd0) begin
          e.exc   = 1'b1;
          e.cause = ooo_pkg::EXC_DIV_ZERO;
        end else begin
          e.data = req.opa / req.opb;
        end
      end
      default: begin
        e.exc   = 1'b1;
        e.cause = ooo_pkg::EXC_ILLEGAL;
      end
    endcase
    return e;
  endfunction

  // Builds a request at the running PC
  function automatic ooo_pkg::issue_req_t next_req(input ooo_pkg::op_t op,
                                                   input logic [4:0] rd,
                                                   input ooo_pkg::word_t opa,
                                                   input ooo_pkg::word_t opb);
    ooo_pkg::issue_req_t r;
    r.op   = op;
    r.rd   = rd;
    r.opa  = opa;
    r.opb  = opb;
    r.pc   = pc_now;
    pc_now = pc_now + 32'd4;
    return r;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("Error: %s = 0x%08h, expected 0x%08h", name, got, exp);
      errors++;
    end
  endtask

  // Called just after a rising edge and returns after the accepting edge
  task automatic send(input ooo_pkg::issue_req_t req);
    issue_valid <= 1'b1;
    issue_req   <= req;
    @(negedge CLK);
    // Request stays unchanged while stalled
    while (issue_stall) begin
      @(negedge CLK);
    end
    if (req.op != ooo_pkg::OP_NOP) begin
      exp_q.push_back(model(req));
    end
    @(posedge CLK);
  endtask

  task automatic idle();
    issue_valid <= 1'b0;
    issue_req   <= '0;
  endtask

  // Waits until every expected result has retired or been flushed
  task automatic wait_drain();
    do begin
      @(negedge CLK);
    end while (exp_q.size() != 0 || !cb_empty);
    @(posedge CLK);
  endtask

  task automatic print_summary();
    $display("Summary: %0d check errors, %0d assertion failures, %0d commits, %0d exceptions",
             errors, u_dut.u_cb.u_cb_chk.fail_count, commits, exceptions);
  endtask

  // Compare on the falling edge where the head outputs are settled
  always @(negedge CLK) begin
    expect_t e;
    if (nRST) begin
      if (cb_full && issue_stall) begin
        seen_full = 1'b1;
      end
      if (commit_valid) begin
        commits++;
        if (exp_q.size() == 0) begin
          $display("Commit to x%0d with no request outstanding", commit.rd);
          errors++;
        end else begin
          e = exp_q.pop_front();
          if (e.exc) begin
            $display("Commit seen where an exception was expected");
            errors++;
          end else begin
            check_value("commit.rd", 32'(commit.rd), 32'(e.rd));
            check_value("commit.data", commit.data, e.data);
            check_value("commit.wen", 32'(commit.wen), 32'(e.wen));
          end
        end
      end
      if (exc_valid) begin
        exceptions++;
        if (exp_q.size() == 0) begin
          $display("Exception reported with no request outstanding");
          errors++;
        end else if (!exp_q[0].exc) begin
          $display("Exception reported where a commit was expected");
          errors++;
        end else begin
          check_value("exc_cause", 32'(exc_cause), 32'(exp_q[0].cause));
          check_value("exc_epc", 32'(exc_epc), 32'(exp_q[0].epc));
        end
        // Younger requests are flushed with the trap
        exp_q.delete();
      end
    end
  end

  // Run limit
  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge CLK);
      cycles++;
    end
    $display("Run stopped after %0d cycles without finishing", MAX_CYCLES);
    print_summary();
    $display("Test failed");
    $finish;
  end

  initial begin
    ooo_pkg::op_t   op;
    ooo_pkg::word_t divisor;
    int unsigned    exc_before;
    int unsigned    commit_before;
    void'($urandom(SEED));
    issue_valid <= 1'b0;
    issue_req   <= '0;
    pc_now      = 32'h0000_1000;
    seen_full   = 1'b0;
    @(posedge CLK);
    while (!nRST) begin
      @(posedge CLK);
    end
    // Idle state out of reset
    @(negedge CLK);
    check_value("issue_stall", 32'(issue_stall), 32'd0);
    check_value("commit_valid", 32'(commit_valid), 32'd0);
    check_value("exc_valid", 32'(exc_valid), 32'd0);
    check_value("cb_empty", 32'(cb_empty), 32'd1);
    @(posedge CLK);

    // Single ALU ops into an empty buffer with an x0 target among them
    send(next_req(ooo_pkg::OP_ADD, 5'd1, 32'd5, 32'd7));
    idle();
    wait_drain();
    send(next_req(ooo_pkg::OP_SUB, 5'd2, 32'd3, 32'd10));
    idle();
    wait_drain();
    send(next_req(ooo_pkg::OP_XOR, 5'd0, 32'hdead_beef, 32'h0f0f_0f0f));
    idle();
    wait_drain();
    send(next_req(ooo_pkg::OP_SLL, 5'd3, 32'h8000_0001, 32'h0000_0024));
    idle();
    wait_drain();

    // Slow divide ahead of quick ALU ops still retired in order
    send(next_req(ooo_pkg::OP_DIV, 5'd5, 32'd100, 32'd7));
    send(next_req(ooo_pkg::OP_ADD, 5'd6, 32'd1, 32'd2));
    send(next_req(ooo_pkg::OP_XOR, 5'd7, 32'h1234_5678, 32'hffff_0000));
    send(next_req(ooo_pkg::OP_SLL, 5'd8, 32'd3, 32'd4));
    idle();
    wait_drain();

    // Back-to-back random mix behind a divide fills the buffer
    seen_full = 1'b0;
    send(next_req(ooo_pkg::OP_DIV, 5'($urandom), $urandom, $urandom | 32'h1));
    for (int i = 0; i < 15; i++) begin
      if (i < 7) begin
        op = ooo_pkg::op_t'($urandom_range(4, 1));
      end else begin
        op = ooo_pkg::op_t'($urandom_range(6, 1));
      end
      divisor = $urandom;
      if (op == ooo_pkg::OP_DIV) begin
        divisor = divisor | 32'h1;
      end
      send(next_req(op, 5'($urandom), $urandom, divisor));
    end
    idle();
    wait_drain();
    check_value("cb_full", 32'(seen_full), 32'd1);

    // Divide by zero at the head drops the younger ops
    exc_before = exceptions;
    pc_now     = 32'hf123_4560;
    send(next_req(ooo_pkg::OP_DIV, 5'd4, 32'd50, 32'd0));
    send(next_req(ooo_pkg::OP_ADD, 5'd10, 32'd1, 32'd1));
    send(next_req(ooo_pkg::OP_SUB, 5'd11, 32'd9, 32'd4));
    idle();
    wait_drain();
    check_value("exc_valid count", exceptions - exc_before, 32'd1);
    send(next_req(ooo_pkg::OP_ADD, 5'd12, 32'd20, 32'd22));
    send(next_req(ooo_pkg::OP_XOR, 5'd13, 32'haaaa_5555, 32'h5555_aaaa));
    idle();
    wait_drain();

    // Illegal op ahead of two multiplies still in flight
    exc_before = exceptions;
    send(next_req(ooo_pkg::OP_ILLEGAL, 5'd14, 32'd0, 32'd0));
    send(next_req(ooo_pkg::OP_MUL, 5'd15, 32'd1000, 32'd3000));
    send(next_req(ooo_pkg::OP_MUL, 5'd16, 32'hffff_ffff, 32'd2));
    idle();
    wait_drain();
    // Cancelled lanes must not write back later
    repeat (8) @(negedge CLK);
    check_value("exc_valid count", exceptions - exc_before, 32'd1);
    check_value("cb_empty", 32'(cb_empty), 32'd1);
    check_value("issue_stall", 32'(issue_stall), 32'd0);
    @(posedge CLK);
    send(next_req(ooo_pkg::OP_ADD, 5'd17, 32'd7, 32'd8));
    idle();
    wait_drain();

    // NOPs are taken without a slot
    commit_before = commits;
    send(next_req(ooo_pkg::OP_NOP, 5'd20, 32'd1, 32'd1));
    idle();
    @(negedge CLK);
    check_value("cb_empty", 32'(cb_empty), 32'd1);
    @(posedge CLK);
    send(next_req(ooo_pkg::OP_ADD, 5'd18, 32'd11, 32'd12));
    send(next_req(ooo_pkg::OP_NOP, 5'd21, 32'd0, 32'd0));
    send(next_req(ooo_pkg::OP_NOP, 5'd22, 32'd0, 32'd0));
    send(next_req(ooo_pkg::OP_XOR, 5'd19, 32'h0000_ffff, 32'h00ff_00ff));
    send(next_req(ooo_pkg::OP_NOP, 5'd23, 32'd0, 32'd0));
    idle();
    wait_drain();
    check_value("commit_valid count", commits - commit_before, 32'd2);

    if (exp_q.size() != 0) begin
      $display("%0d expected results were never retired", exp_q.size());
      errors++;
    end
    print_summary();
    if (errors == 0 && u_dut.u_cb.u_cb_chk.fail_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== test/tb_clock_gen.sv ====
// ----------------------------------------
// Testbench clock and reset generator
// ----------------------------------------
`timescale 1ns/10ps

module tb_clock_gen #(
  parameter int PERIOD       = 8,
  parameter int RESET_CYCLES = 5
) (
  output logic CLK,
  output logic nRST
);

  // Free-running clock
  initial begin
    CLK = 1'b0;
    forever #(PERIOD / 2) CLK = ~CLK;
  end

  // Reset held low for a fixed number of rising edges
  initial begin
    nRST = 1'b0;
    repeat (RESET_CYCLES) @(posedge CLK);
    nRST <= 1'b1;
  end

endmodule
